//--- mem_sub.f
+incdir+.
rtl/mem_sub_pkg.sv
rtl/mem_ctrl.sv
rtl/nocache_unit.sv
rtl/line_cache.sv
rtl/mem_sub_top.sv
test/mem_sub_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the memory subsystem testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f mem_sub.f --top-module mem_sub_tb -o mem_sub_sim

./obj_dir/mem_sub_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Errors found" sim.log; then
  echo "simulation FAILED"
  exit 1
fi

if ! grep -q "No errors" sim.log; then
  echo "simulation ended without a result"
  exit 1
fi

echo "simulation passed"

//--- test/mem_sub_tb.sv
// ==================================================
// testbench: clock, reset, bus memory model with
// random latency, directed and random requests
// ==================================================
`default_nettype none
`include "mem_sub_params.svh"

module mem_sub_tb
  import mem_sub_pkg::*;
;

  localparam int N_REQ     = 321;   // 21 directed plus 300 random
  localparam int MAX_CYCLE = 200 * N_REQ + 1000;

  logic     clk = 1'b0;
  logic     rst = 1'b1;
  logic     i_req = 1'b0;
  mem_req_t i_mem = '0;
  logic     o_ack;
  dword_t   o_rdata;
  logic     o_bus_valid;
  bus_req_t o_bus;
  logic     i_bus_ready = 1'b0;
  line_t    i_bus_rdata = '0;

  integer   seed = 88;
  int       errors = 0;
  int       cycles = 0;
  int       hs_cnt = 0;
  int       valid_cycles = 0;
  int       wait_cnt = 0;
  logic     cur_op = 1'b0;
  dword_t   exp_rdata = '0;
  bus_req_t last_bus = '0;
  addr_t    rd_base;

  logic [7:0] bus_mem [addr_t];   // what the bus sees
  logic [7:0] shadow  [addr_t];   // reference copy

  mem_sub_top DUT (
    .clk         (clk),
    .rst         (rst),
    .i_req       (i_req),
    .i_mem       (i_mem),
    .o_ack       (o_ack),
    .o_rdata     (o_rdata),
    .o_bus_valid (o_bus_valid),
    .o_bus       (o_bus),
    .i_bus_ready (i_bus_ready),
    .i_bus_rdata (i_bus_rdata)
  );

  always #20 clk = ~clk;

  assign rd_base = {o_bus.addr[63:3], 3'b000};  // read data starts at the aligned dword

  // fill byte folded from every address byte
  function automatic logic [7:0] fill_byte(input addr_t a);
    logic [7:0] f;
    f = 8'h5a;
    for (int i = 0; i < 8; i++) f = f ^ a[i*8 +: 8] ^ 8'(i);
    return f;
  endfunction

  // full aligned dword with all earlier writes
  function automatic dword_t ref_read(input addr_t a);
    addr_t  base;
    dword_t d;
    base = {a[63:3], 3'b000};
    for (int i = 0; i < 8; i++) begin
      d[i*8 +: 8] = shadow.exists(base + i) ? shadow[base + i] : fill_byte(base + i);
    end
    return d;
  endfunction

  function automatic bus_size_t size_code(input bytes_t b);
    return bus_size_t'($clog2(int'(b) + 1));
  endfunction

  // bus memory model with ready after 0 to 5 idle cycles
  always @(posedge clk) begin
    if (o_bus_valid) valid_cycles <= valid_cycles + 1;
    if (o_bus_valid && i_bus_ready) begin
      hs_cnt   <= hs_cnt + 1;
      last_bus <= o_bus;
      if (o_bus.op) begin
        for (int i = 0; i < (1 << o_bus.size); i++) begin
          bus_mem[o_bus.addr + i] = o_bus.wdata[(int'(o_bus.addr[2:0]) + i)*8 +: 8];
        end
      end
      i_bus_ready <= 1'b0;
      wait_cnt    <= ($random(seed) & 32'h7fff_ffff) % 6;
    end else if (o_bus_valid && !i_bus_ready) begin
      if (wait_cnt == 0) begin
        i_bus_ready <= 1'b1;
        for (int i = 0; i < 64; i++) begin
          i_bus_rdata[i*8 +: 8] <= bus_mem.exists(rd_base + i) ?
                                   bus_mem[rd_base + i] : fill_byte(rd_base + i);
        end
      end else begin
        wait_cnt <= wait_cnt - 1;
      end
    end
  end

  // read data compare on every ack
  always @(posedge clk) begin
    if (!rst && o_ack && !cur_op) begin
      assert (o_rdata == exp_rdata) else begin
        errors++;
        $display("FAIL o_rdata got %h expected %h", o_rdata, exp_rdata);
      end
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLE) begin
      $display("timeout: run exceeded %0d cycles, %0d errors", MAX_CYCLE, errors);
      $display("Errors found");
      $finish;
    end
  end

  // one request held until ack
  // an exp_hs of -1 allows any handshake count
  task automatic issue(input logic op, input addr_t addr, input bytes_t b,
                       input dword_t wd, input int exp_hs);
    logic io;
    int   n;
    int   hs_base;
    int   vc_base;
    int   hs_n;
    io = (addr < addr_t'(`MS_IO_LIMIT));
    @(posedge clk);
    hs_base = hs_cnt;
    vc_base = valid_cycles;
    cur_op  = op;
    if (op) begin
      for (n = 0; n <= int'(b); n++) shadow[addr + n] = wd[(int'(addr[2:0]) + n)*8 +: 8];
    end else begin
      exp_rdata = ref_read(addr);
    end
    i_req       <= 1'b1;
    i_mem.addr  <= addr;
    i_mem.wdata <= wd;
    i_mem.bytes <= b;
    i_mem.op    <= op;
    @(posedge clk);
    while (!o_ack) @(posedge clk);
    i_req <= 1'b0;
    hs_n = hs_cnt - hs_base;
    if (exp_hs >= 0) begin
      assert (hs_n == exp_hs) else begin
        errors++;
        $display("FAIL hs_cnt got %h expected %h at addr %h", hs_n, exp_hs, addr);
      end
      if (exp_hs == 0) begin
        assert (valid_cycles == vc_base) else begin
          errors++;
          $display("bus valid was raised on a request that should hit in the cache");
        end
      end
    end
    if (hs_n > 0) begin
      assert (last_bus.blks == 8'h00) else begin
        errors++;
        $display("FAIL o_bus.blks got %h expected %h", last_bus.blks, 8'h00);
      end
      assert (last_bus.op == op) else begin
        errors++;
        $display("FAIL o_bus.op got %h expected %h", last_bus.op, op);
      end
      if (io || op) begin
        assert (last_bus.size == size_code(b) && last_bus.addr == addr) else begin
          errors++;
          $display("FAIL o_bus.size/addr got %h/%h expected %h/%h",
                   last_bus.size, last_bus.addr, size_code(b), addr);
        end
      end else begin
        assert (last_bus.size == `MS_SIZE_L && last_bus.addr == {addr[63:6], 6'd0}) else begin
          errors++;
          $display("FAIL o_bus.size/addr got %h/%h expected %h/%h",
                   last_bus.size, last_bus.addr, `MS_SIZE_L, {addr[63:6], 6'd0});
        end
      end
    end
  endtask

  function automatic addr_t rand_addr(input logic io, input bytes_t b);
    addr_t base;
    addr_t lane;
    if (io) begin
      base = 64'h0000_1000 + addr_t'((($random(seed) & 32'h7fff_ffff) % 64) * 8);
    end else begin
      case (($random(seed) & 32'h7fff_ffff) % 3)
        0:       base = 64'h2000_0000;
        1:       base = 64'h2000_0200;   // same index with another tag
        default: base = 64'h3000_0000;
      endcase
      base = base + addr_t'(($random(seed) & 7) * 64) + addr_t'(($random(seed) & 7) * 8);
    end
    lane = addr_t'($random(seed) & 7) & ~addr_t'(b);
    return base + lane;
  endfunction

  initial begin
    bytes_t sizes [4];
    bytes_t b;
    logic   io;
    logic   op;
    sizes = '{3'd0, 3'd1, 3'd3, 3'd7};
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    // quiet after reset
    repeat (5) begin
      @(posedge clk);
      assert (!o_ack && !o_bus_valid) else begin
        errors++;
        $display("ack or bus valid went high before any request");
      end
    end
    // uncached writes and reads of every size
    foreach (sizes[i]) begin
      issue(1'b1, 64'h0000_2000 + addr_t'(8 * i) + addr_t'(sizes[i] == 0 ? 3 : 0),
            sizes[i], {$random(seed), $random(seed)}, 1);
      issue(1'b0, 64'h0000_2000 + addr_t'(8 * i), sizes[i], '0, 1);
    end
    // cached miss then hits in the same line
    issue(1'b0, 64'h2000_0140, 3'd7, '0, 1);
    for (int w = 0; w < 8; w++) issue(1'b0, 64'h2000_0140 + addr_t'(w * 8), 3'd7, '0, 0);
    // write hit and the merged word without refill
    issue(1'b1, 64'h2000_0154, 3'd3, 64'hdead_beef_0bad_f00d, 1);
    issue(1'b0, 64'h2000_0150, 3'd7, '0, 0);
    issue(1'b1, 64'h2000_0159, 3'd0, 64'h0000_0000_0000_a500, 1);
    issue(1'b0, 64'h2000_0158, 3'd7, '0, 0);
    // random mix over both regions
    for (int r = 0; r < 300; r++) begin
      b  = sizes[$random(seed) & 3];
      io = 1'($random(seed));
      op = 1'($random(seed));
      issue(op, rand_addr(io, b), b, {$random(seed), $random(seed)}, (io || op) ? 1 : -1);
    end
    repeat (4) @(posedge clk);
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- rtl/mem_sub_top.sv
// ==================================================
// memory subsystem top: controller, uncached unit
// and line cache on one bus port
// ==================================================
`default_nettype none

module mem_sub_top
  import mem_sub_pkg::*;
(
  input  wire              clk,
  input  wire              rst,
  input  wire              i_req,
  input  wire mem_req_t    i_mem,
  output logic             o_ack,
  output dword_t           o_rdata,
  output logic             o_bus_valid,
  output bus_req_t         o_bus,
  input  wire              i_bus_ready,
  input  wire line_t       i_bus_rdata
);

  // controller to path wiring
  logic     nc_req;
  logic     c_req;
  mem_req_t path_mem;
  logic     nc_ack;
  logic     c_ack;
  dword_t   nc_rdata;
  dword_t   c_rdata;

  // path bus sides
  logic     nc_bus_valid;
  logic     c_bus_valid;
  bus_req_t nc_bus;
  bus_req_t c_bus;
  logic     nc_bus_ready;
  logic     c_bus_ready;
  line_t    path_rdata;

  mem_ctrl u_ctrl (
    .clk            (clk),
    .rst            (rst),
    .i_req          (i_req),
    .i_mem          (i_mem),
    .o_ack          (o_ack),
    .o_rdata        (o_rdata),
    .o_nc_req       (nc_req),
    .o_c_req        (c_req),
    .o_path_mem     (path_mem),
    .i_nc_ack       (nc_ack),
    .i_c_ack        (c_ack),
    .i_nc_rdata     (nc_rdata),
    .i_c_rdata      (c_rdata),
    .i_nc_bus_valid (nc_bus_valid),
    .i_c_bus_valid  (c_bus_valid),
    .i_nc_bus       (nc_bus),
    .i_c_bus        (c_bus),
    .o_nc_bus_ready (nc_bus_ready),
    .o_c_bus_ready  (c_bus_ready),
    .o_bus_valid    (o_bus_valid),
    .o_bus          (o_bus),
    .i_bus_ready    (i_bus_ready),
    .i_bus_rdata    (i_bus_rdata),
    .o_path_rdata   (path_rdata)
  );

  nocache_unit u_nocache (
    .clk         (clk),
    .rst         (rst),
    .i_req       (nc_req),
    .i_mem       (path_mem),
    .o_ack       (nc_ack),
    .o_rdata     (nc_rdata),
    .o_bus_valid (nc_bus_valid),
    .o_bus       (nc_bus),
    .i_bus_ready (nc_bus_ready),
    .i_bus_rdata (path_rdata)
  );

  line_cache u_cache (
    .clk         (clk),
    .rst         (rst),
    .i_req       (c_req),
    .i_mem       (path_mem),
    .o_ack       (c_ack),
    .o_rdata     (c_rdata),
    .o_bus_valid (c_bus_valid),
    .o_bus       (c_bus),
    .i_bus_ready (c_bus_ready),
    .i_bus_rdata (path_rdata)
  );

endmodule

`default_nettype wire

//--- rtl/line_cache.sv
// ==================================================
// direct-mapped write-through cache, 64-byte lines,
// single-transfer refill and write byte merge
// ==================================================
`default_nettype none
`include "mem_sub_params.svh"

module line_cache
  import mem_sub_pkg::*;
(
  input  wire              clk,
  input  wire              rst,
  input  wire              i_req,
  input  wire mem_req_t    i_mem,
  output logic             o_ack,
  output dword_t           o_rdata,
  output logic             o_bus_valid,
  output bus_req_t         o_bus,
  input  wire              i_bus_ready,
  input  wire line_t       i_bus_rdata
);

  localparam int INDEX_W  = $clog2(`MS_CACHE_LINES);
  localparam int WORD_W   = `MS_OFFSET_W - 3;        // dword select
  localparam int TAG_W    = `MS_ADDR_W - INDEX_W - `MS_OFFSET_W;
  localparam int DW_BYTES = `MS_DWORD_W / 8;

  // storage
  logic [`MS_CACHE_LINES-1:0] valid_q;
  logic [TAG_W-1:0]           tag_q  [`MS_CACHE_LINES];
  line_t                      data_q [`MS_CACHE_LINES];

  logic [INDEX_W-1:0]  idx;
  logic [TAG_W-1:0]    tag;
  logic [WORD_W-1:0]   word;
  logic                hit;
  logic                hs;
  logic                busy;
  logic                lookup_q;
  line_t               cur_line;
  logic [DW_BYTES-1:0] dw_mask;
  line_t               merged;

  assign idx      = i_mem.addr[`MS_OFFSET_W +: INDEX_W];
  assign tag      = i_mem.addr[`MS_ADDR_W-1 -: TAG_W];
  assign word     = i_mem.addr[3 +: WORD_W];
  assign cur_line = data_q[idx];
  assign hit      = valid_q[idx] && (tag_q[idx] == tag);
  assign hs       = o_bus_valid && i_bus_ready;
  assign busy     = lookup_q || o_bus_valid || o_ack;

  // store lanes inside the addressed dword
  assign dw_mask = DW_BYTES'(((2 << i_mem.bytes) - 1) << i_mem.addr[2:0]);

  always_comb begin
    merged = cur_line;
    for (int b = 0; b < DW_BYTES; b++) begin
      if (dw_mask[b]) begin
        merged[word*`MS_DWORD_W + b*8 +: 8] = i_mem.wdata[b*8 +: 8];
      end
    end
  end

  // lookup cycle, then either ack or go to the bus
  always_ff @(posedge clk) begin
    if (rst) begin
      lookup_q    <= 1'b0;
      o_bus_valid <= 1'b0;
      o_ack       <= 1'b0;
    end else begin
      lookup_q <= i_req && !busy;
      o_ack    <= 1'b0;
      if (lookup_q) begin
        if (!i_mem.op && hit) begin
          o_ack <= 1'b1;         // read hit
        end else begin
          o_bus_valid <= 1'b1;   // refill or write-through
        end
      end
      if (hs) begin
        o_bus_valid <= 1'b0;
        o_ack       <= 1'b1;
      end
    end
  end

  // bus request, built in the lookup cycle
  always_ff @(posedge clk) begin
    if (lookup_q) begin
      o_bus.op   <= i_mem.op;
      o_bus.blks <= '0;
      if (i_mem.op) begin
        o_bus.addr  <= i_mem.addr;
        o_bus.size  <= to_bus_size(i_mem.bytes);
        o_bus.wdata <= {{(`MS_LINE_W - `MS_DWORD_W){1'b0}}, i_mem.wdata};
      end else begin
        // whole line at the aligned address
        o_bus.addr  <= {i_mem.addr[`MS_ADDR_W-1:`MS_OFFSET_W], {`MS_OFFSET_W{1'b0}}};
        o_bus.size  <= `MS_SIZE_L;
        o_bus.wdata <= '0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
    end else if (hs && !i_mem.op) begin
      valid_q[idx] <= 1'b1;      // line filled
    end
  end

  // line data, tags and returned word
  always_ff @(posedge clk) begin
    if (hs) begin
      if (!i_mem.op) begin
        data_q[idx] <= i_bus_rdata;
        tag_q[idx]  <= tag;
        o_rdata     <= i_bus_rdata[word*`MS_DWORD_W +: `MS_DWORD_W];
      end else if (hit) begin
        data_q[idx] <= merged;   // keep line in step with memory
      end
    end else if (lookup_q) begin
      o_rdata <= cur_line[word*`MS_DWORD_W +: `MS_DWORD_W];
    end
  end

endmodule

`default_nettype wire

//--- rtl/nocache_unit.sv
// ==================================================
// uncached access: one single-beat bus transfer
// of 1, 2, 4 or 8 bytes
// ==================================================
`default_nettype none
`include "mem_sub_params.svh"

module nocache_unit
  import mem_sub_pkg::*;
(
  input  wire              clk,
  input  wire              rst,
  input  wire              i_req,
  input  wire mem_req_t    i_mem,
  output logic             o_ack,
  output dword_t           o_rdata,
  output logic             o_bus_valid,
  output bus_req_t         o_bus,
  input  wire              i_bus_ready,
  input  wire line_t       i_bus_rdata
);

  logic hs;
  logic start;

  assign hs    = o_bus_valid && i_bus_ready;
  assign start = i_req && !o_ack;   // no restart in the ack cycle

  always_ff @(posedge clk) begin
    if (rst) begin
      o_bus_valid <= 1'b0;
      o_ack       <= 1'b0;
    end else begin
      o_ack <= 1'b0;
      if (start) begin
        if (hs) begin
          o_bus_valid <= 1'b0;
          o_ack       <= 1'b1;
        end else begin
          o_bus_valid <= 1'b1;   // raise or keep holding
        end
      end
    end
  end

  // transfer fields, frozen once valid is up
  always_ff @(posedge clk) begin
    if (start && !o_bus_valid) begin
      o_bus.op    <= i_mem.op;
      o_bus.addr  <= i_mem.addr;
      o_bus.size  <= to_bus_size(i_mem.bytes);
      o_bus.blks  <= '0;
      o_bus.wdata <= {{(`MS_LINE_W - `MS_DWORD_W){1'b0}}, i_mem.wdata};
    end
  end

  // read data lives in the low word
  always_ff @(posedge clk) begin
    if (hs) o_rdata <= i_bus_rdata[`MS_DWORD_W-1:0];
  end

endmodule

`default_nettype wire

//--- rtl/mem_ctrl.sv
// ==================================================
// request controller: region decode, path routing,
// bus arbitration and core ack
// ==================================================
`default_nettype none
`include "mem_sub_params.svh"

module mem_ctrl
  import mem_sub_pkg::*;
(
  input  wire              clk,
  input  wire              rst,
  // core port
  input  wire              i_req,
  input  wire mem_req_t    i_mem,
  output logic             o_ack,
  output dword_t           o_rdata,
  // path requests
  output logic             o_nc_req,
  output logic             o_c_req,
  output mem_req_t         o_path_mem,
  input  wire              i_nc_ack,
  input  wire              i_c_ack,
  input  wire dword_t      i_nc_rdata,
  input  wire dword_t      i_c_rdata,
  // path bus sides
  input  wire              i_nc_bus_valid,
  input  wire              i_c_bus_valid,
  input  wire bus_req_t    i_nc_bus,
  input  wire bus_req_t    i_c_bus,
  output logic             o_nc_bus_ready,
  output logic             o_c_bus_ready,
  // outward bus
  output logic             o_bus_valid,
  output bus_req_t         o_bus,
  input  wire              i_bus_ready,
  input  wire line_t       i_bus_rdata,
  output line_t            o_path_rdata
);

  ctrl_state_t state_q;
  mem_req_t    mem_q;
  logic        is_io;

  assign is_io = (i_mem.addr < addr_t'(`MS_IO_LIMIT));  // io region decode

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= IDLE;
    end else begin
      case (state_q)
        IDLE:     if (i_req) state_q <= is_io ? UNCACHED : CACHED;
        UNCACHED: if (i_nc_ack) state_q <= DONE;
        CACHED:   if (i_c_ack) state_q <= DONE;
        default:  state_q <= IDLE;   // ack cycle
      endcase
    end
  end

  // request latch and returned word
  always_ff @(posedge clk) begin
    if (state_q == IDLE && i_req) mem_q <= i_mem;
    if (state_q == UNCACHED && i_nc_ack) o_rdata <= i_nc_rdata;
    if (state_q == CACHED && i_c_ack) o_rdata <= i_c_rdata;
  end

  assign o_ack      = (state_q == DONE);
  assign o_nc_req   = (state_q == UNCACHED);
  assign o_c_req    = (state_q == CACHED);
  assign o_path_mem = mem_q;

  // grant follows the state, one transfer in flight
  always_comb begin
    o_bus_valid    = 1'b0;
    o_bus          = '0;
    o_nc_bus_ready = 1'b0;
    o_c_bus_ready  = 1'b0;
    case (state_q)
      UNCACHED: begin
        o_bus_valid    = i_nc_bus_valid;
        o_bus          = i_nc_bus;
        o_nc_bus_ready = i_bus_ready;
      end
      CACHED: begin
        o_bus_valid   = i_c_bus_valid;
        o_bus         = i_c_bus;
        o_c_bus_ready = i_bus_ready;
      end
      default: ;
    endcase
  end

  assign o_path_rdata = i_bus_rdata;  // both paths see read data

endmodule

`default_nettype wire

//--- rtl/mem_sub_pkg.sv
// ==================================================
// shared types: vectors, request and bus structs,
// controller states, size mapping
// ==================================================
`default_nettype none
`include "mem_sub_params.svh"

package mem_sub_pkg;

  typedef logic [`MS_ADDR_W-1:0]  addr_t;
  typedef logic [`MS_DWORD_W-1:0] dword_t;
  typedef logic [`MS_LINE_W-1:0]  line_t;
  typedef logic [2:0]             bytes_t;     // byte count minus one
  typedef logic [2:0]             bus_size_t;

  // core side request, held until ack
  typedef struct packed {
    addr_t  addr;
    dword_t wdata;   // byte lanes follow addr[2:0]
    bytes_t bytes;
    logic   op;      // 0 read, 1 write
  } mem_req_t;

  // one bus transfer
  typedef struct packed {
    logic      op;
    addr_t     addr;
    bus_size_t size;
    logic [7:0] blks;  // beats minus one
    line_t     wdata;
  } bus_req_t;

  typedef enum logic [1:0] {IDLE, UNCACHED, CACHED, DONE} ctrl_state_t;

  // byte count to bus size code, odd counts fall back to a byte
  function automatic bus_size_t to_bus_size(input bytes_t b);
    case (b)
      3'd0:    return `MS_SIZE_B;
      3'd1:    return `MS_SIZE_H;
      3'd3:    return `MS_SIZE_W;
      3'd7:    return `MS_SIZE_D;
      default: return `MS_SIZE_B;
    endcase
  endfunction

endpackage

`default_nettype wire

//--- mem_sub_params.svh
// ==================================================
// widths, io limit, cache geometry and bus size
// codes for the memory subsystem
// ==================================================
`ifndef MEM_SUB_PARAMS_SVH
`define MEM_SUB_PARAMS_SVH

// datapath widths
`define MS_ADDR_W   64
`define MS_DWORD_W  64
`define MS_LINE_W   512

// everything below this goes uncached
`define MS_IO_LIMIT 64'h0000_0000_1000_0000

// cache geometry
`define MS_CACHE_LINES 8
`define MS_OFFSET_W    6    // 64-byte lines

// bus size codes, log2 of the byte count
`define MS_SIZE_B 3'd0
`define MS_SIZE_H 3'd1
`define MS_SIZE_W 3'd2
`define MS_SIZE_D 3'd3
`define MS_SIZE_L 3'd6      // whole line

`endif
